//--- dodge_pkg.sv
package dodge_pkg;

	localparam int GRID_CELLS = 5;
	localparam int BLOCK_SLOTS = 10;
	localparam int CELL_BITS = 3;
	localparam int MAP_BITS = GRID_CELLS * GRID_CELLS;

	localparam logic [3:0] ROTATE_SECONDS = 4'd5;
	localparam logic [3:0] SECONDS_MAX = 4'd15;

	// Last row or column index and the centre cell where the player starts
	localparam logic [CELL_BITS-1:0] CELL_LAST = CELL_BITS'(GRID_CELLS - 1);
	localparam logic [CELL_BITS-1:0] CELL_MID = CELL_BITS'(GRID_CELLS / 2);

	typedef struct packed
	{
		logic [CELL_BITS-1:0] col;
		logic [CELL_BITS-1:0] row;
	} grid_pos_t;

	typedef enum logic [1:0]
	{
		DIR_DOWN  = 2'd0,
		DIR_LEFT  = 2'd1,
		DIR_UP    = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_t;

	typedef struct packed
	{
		logic left;
		logic right;
		logic up;
		logic down;
	} buttons_t;

	typedef struct packed
	{
		logic clear;
		logic step;
		logic spawn;
	} block_cmd_t;

endpackage

//--- seg_decoder.sv
module seg_decoder (
	input  logic [3:0] digit,
	output logic [6:0] segments
);

	// Segment g is bit 6, a lit segment is 0
	always_comb
	begin
		case (digit)
			4'd0: segments = 7'b100_0000;
			4'd1: segments = 7'b111_1001;
			4'd2: segments = 7'b010_0100;
			4'd3: segments = 7'b011_0000;
			4'd4: segments = 7'b001_1001;
			4'd5: segments = 7'b001_0010;
			4'd6: segments = 7'b000_0010;
			4'd7: segments = 7'b111_1000;
			4'd8: segments = 7'b000_0000;
			4'd9: segments = 7'b001_1000;
			default: segments = 7'b111_1111;
		endcase
	end

endmodule

//--- second_counter.sv
module second_counter import dodge_pkg::*; #(
	parameter int SECOND_CYCLES = 50_000_000
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       playing,
	output logic [3:0] seconds,
	output logic [6:0] hex0,
	output logic [6:0] hex1
);

	localparam int TICK_BITS = (SECOND_CYCLES > 1) ? $clog2(SECOND_CYCLES) : 1;

	logic [TICK_BITS-1:0] tick_timer;
	logic playing_q;
	logic start;
	logic tick;
	logic [3:0] ones;
	logic [3:0] tens;

	assign start = playing && !playing_q;
	assign tick = playing && (tick_timer == TICK_BITS'(SECOND_CYCLES - 1));

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			playing_q <= 1'b0;
			tick_timer <= '0;
			seconds <= '0;
			ones <= '0;
			tens <= '0;
		end
		else
		begin
			playing_q <= playing;
			tick_timer <= (!playing || tick) ? '0 : tick_timer + 1'b1;
			if (start)
			begin
				seconds <= '0;
				ones <= '0;
				tens <= '0;
			end
			else if (tick)
			begin
				if (seconds != SECONDS_MAX)
					seconds <= seconds + 1'b1;
				ones <= (ones == 4'd9) ? '0 : ones + 1'b1;
				if (ones == 4'd9)
					tens <= (tens == 4'd9) ? '0 : tens + 1'b1;
			end
		end
	end

	seg_decoder low_digit (.digit(ones), .segments(hex0));
	seg_decoder high_digit (.digit(tens), .segments(hex1));

endmodule

//--- player_mover.sv
module player_mover import dodge_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  block_cmd_t cmd,
	input  dir_t       direction,
	input  buttons_t   buttons,
	output grid_pos_t  player
);

	buttons_t moves;
	dir_t last_dir;

	// Buttons are turned so that "down" always points along the block travel
	always_comb
	begin
		case (direction)
			DIR_LEFT:
				moves = '{left: buttons.down, right: buttons.up, up: buttons.left, down: buttons.right};
			DIR_UP:
				moves = '{left: buttons.right, right: buttons.left, up: buttons.down, down: buttons.up};
			DIR_RIGHT:
				moves = '{left: buttons.up, right: buttons.down, up: buttons.right, down: buttons.left};
			default:
				moves = buttons;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			player <= '{col: CELL_MID, row: CELL_MID};
			last_dir <= DIR_DOWN;
		end
		else
		begin
			last_dir <= direction;
			if (cmd.clear && direction == last_dir)
				player <= '{col: CELL_MID, row: CELL_MID}; // A changed direction means rotation, keep the cell
			else if (cmd.step)
			begin
				if (moves.left && !moves.right && player.col != '0)
					player.col <= player.col - 1'b1;
				else if (moves.right && !moves.left && player.col != CELL_LAST)
					player.col <= player.col + 1'b1;
				if (moves.up && !moves.down && player.row != '0)
					player.row <= player.row - 1'b1;
				else if (moves.down && !moves.up && player.row != CELL_LAST)
					player.row <= player.row + 1'b1;
			end
		end
	end

endmodule

//--- block_field.sv
module block_field import dodge_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  block_cmd_t          cmd,
	input  dir_t                direction,
	input  grid_pos_t           spawn_cell,
	input  grid_pos_t           player,
	output logic [MAP_BITS-1:0] block_map,
	output logic                collision
);

	logic [BLOCK_SLOTS-1:0] slot_valid;
	grid_pos_t slot_pos [BLOCK_SLOTS];
	logic [3:0] load_ptr;

	function automatic logic at_far_edge(input grid_pos_t pos, input dir_t dir);
		case (dir)
			DIR_LEFT:  return pos.col == '0;
			DIR_UP:    return pos.row == '0;
			DIR_RIGHT: return pos.col == CELL_LAST;
			default:   return pos.row == CELL_LAST;
		endcase
	endfunction

	function automatic grid_pos_t advance(input grid_pos_t pos, input dir_t dir);
		grid_pos_t moved;
		moved = pos;
		case (dir)
			DIR_LEFT:  moved.col = pos.col - 1'b1;
			DIR_UP:    moved.row = pos.row - 1'b1;
			DIR_RIGHT: moved.col = pos.col + 1'b1;
			default:   moved.row = pos.row + 1'b1;
		endcase
		return moved;
	endfunction

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			slot_valid <= '0;
			load_ptr <= '0;
		end
		else if (cmd.clear)
		begin
			slot_valid <= '0;
			load_ptr <= '0;
		end
		else
		begin
			for (int i = 0; i < BLOCK_SLOTS; i++)
			begin
				if (cmd.spawn && load_ptr == 4'(i))
					slot_valid[i] <= 1'b1; // A fresh block waits one step before moving
				else if (cmd.step && slot_valid[i] && at_far_edge(slot_pos[i], direction))
					slot_valid[i] <= 1'b0;
			end
			if (cmd.spawn)
				load_ptr <= (load_ptr == 4'(BLOCK_SLOTS - 1)) ? '0 : load_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < BLOCK_SLOTS; i++)
		begin
			if (cmd.spawn && load_ptr == 4'(i))
				slot_pos[i] <= spawn_cell;
			else if (cmd.step)
				slot_pos[i] <= advance(slot_pos[i], direction);
		end
	end

	always_comb
	begin
		block_map = '0;
		collision = 1'b0;
		for (int i = 0; i < BLOCK_SLOTS; i++)
		begin
			if (slot_valid[i])
			begin
				block_map[slot_pos[i].row * GRID_CELLS + slot_pos[i].col] = 1'b1;
				if (slot_pos[i] == player)
					collision = 1'b1;
			end
		end
	end

endmodule

//--- spawn_random.sv
module spawn_random import dodge_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  block_cmd_t cmd,
	input  dir_t       direction,
	output grid_pos_t  spawn_cell
);

	logic [3:0] shift_reg;
	logic [3:0] lane;

	assign lane = shift_reg % 4'd5;

	always_ff @(posedge clock)
	begin
		if (!reset)
			shift_reg <= 4'b0110;
		else if (cmd.spawn)
			shift_reg <= {shift_reg[2:0], shift_reg[3] ^ shift_reg[2]};
	end

	// New blocks enter on the edge the blocks travel away from
	always_comb
	begin
		case (direction)
			DIR_LEFT:
				spawn_cell = '{col: CELL_LAST, row: lane[CELL_BITS-1:0]};
			DIR_UP:
				spawn_cell = '{col: lane[CELL_BITS-1:0], row: CELL_LAST};
			DIR_RIGHT:
				spawn_cell = '{col: '0, row: lane[CELL_BITS-1:0]};
			default:
				spawn_cell = '{col: lane[CELL_BITS-1:0], row: '0};
		endcase
	end

endmodule

//--- game_control.sv
module game_control import dodge_pkg::*; #(
	parameter int STEP_CYCLES = 12_500_000
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       go,
	input  logic       go2,
	input  logic       collision,
	input  logic [3:0] seconds,
	output block_cmd_t cmd,
	output dir_t       direction,
	output logic       playing,
	output logic       game_over
);

	localparam int TIMER_BITS = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

	typedef enum logic [1:0]
	{
		IDLE = 2'd0,
		PLAY = 2'd1,
		OVER = 2'd2
	} state_t;

	state_t state, next_state;
	logic [TIMER_BITS-1:0] step_timer;
	logic step_due;
	logic rotate;
	logic rot_pass; // Set for the single IDLE cycle that restarts play after a rotation

	assign step_due = (state == PLAY) && (step_timer == TIMER_BITS'(STEP_CYCLES - 1));
	assign rotate = go2 && (seconds > ROTATE_SECONDS);
	assign playing = (state == PLAY);
	assign game_over = (state == OVER);

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE: if (go || rot_pass) next_state = PLAY;
			PLAY:
			begin
				if (collision)
					next_state = OVER; // Collision wins over rotation
				else if (rotate)
					next_state = IDLE;
			end
			OVER: if (go2) next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	always_comb
	begin
		cmd = '0;
		cmd.clear = (state == IDLE) && (go || rot_pass);
		cmd.step = step_due;
		cmd.spawn = step_due;
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			state <= IDLE;
			step_timer <= '0;
			direction <= DIR_DOWN;
			rot_pass <= 1'b0;
		end
		else
		begin
			state <= next_state;

			if (cmd.clear || step_due)
				step_timer <= '0;
			else if (state == PLAY)
				step_timer <= step_timer + 1'b1;

			if (state == PLAY && !collision && rotate)
			begin
				direction <= dir_t'(direction + 2'd1);
				rot_pass <= 1'b1;
			end
			else if (state == IDLE)
				rot_pass <= 1'b0;
		end
	end

endmodule

//--- dodge_top.sv
module dodge_top import dodge_pkg::*; #(
	parameter int STEP_CYCLES = 12_500_000,
	parameter int SECOND_CYCLES = 50_000_000
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                go,
	input  logic                go2,
	input  buttons_t            buttons,
	output logic                playing,
	output logic                game_over,
	output dir_t                direction,
	output grid_pos_t           player,
	output logic [MAP_BITS-1:0] block_map,
	output logic [6:0]          hex0,
	output logic [6:0]          hex1
);

	block_cmd_t cmd;
	grid_pos_t spawn_cell;
	logic collision;
	logic [3:0] seconds;

	game_control #(
		.STEP_CYCLES(STEP_CYCLES)
	) control0 (
		.clock     (clock),
		.reset     (reset),
		.go        (go),
		.go2       (go2),
		.collision (collision),
		.seconds   (seconds),
		.cmd       (cmd),
		.direction (direction),
		.playing   (playing),
		.game_over (game_over)
	);

	spawn_random random0 (
		.clock      (clock),
		.reset      (reset),
		.cmd        (cmd),
		.direction  (direction),
		.spawn_cell (spawn_cell)
	);

	block_field field0 (
		.clock      (clock),
		.reset      (reset),
		.cmd        (cmd),
		.direction  (direction),
		.spawn_cell (spawn_cell),
		.player     (player),
		.block_map  (block_map),
		.collision  (collision)
	);

	player_mover mover0 (
		.clock     (clock),
		.reset     (reset),
		.cmd       (cmd),
		.direction (direction),
		.buttons   (buttons),
		.player    (player)
	);

	second_counter #(
		.SECOND_CYCLES(SECOND_CYCLES)
	) seconds0 (
		.clock   (clock),
		.reset   (reset),
		.playing (playing),
		.seconds (seconds),
		.hex0    (hex0),
		.hex1    (hex1)
	);

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clock
);

	initial
	begin
		clock = 1'b0;
	end

	always #(PERIOD / 2) clock = ~clock;

endmodule

//--- dodge_tb.sv
module dodge_tb import dodge_pkg::*; ;

	localparam int STEP_CYCLES = 4;
	localparam int SECOND_CYCLES = 8;
	localparam int ROWS = 20;

	typedef struct
	{
		logic go;
		logic go2;
		buttons_t buttons;
		int cycles;
		int col;
		int row;
		logic playing;
		logic game_over;
	} row_t;

	logic clock, reset, go, go2;
	buttons_t buttons;
	logic playing, game_over;
	dir_t direction;
	grid_pos_t player;
	logic [MAP_BITS-1:0] block_map;
	logic [6:0] hex0, hex1;
	row_t stim_table [ROWS];

	// Reference model state
	logic model_ready = 1'b0;
	int m_state, m_timer, m_ptr, m_tick, m_sec, m_ones, m_tens, p_col, p_row;
	logic [1:0] m_dir;
	logic [3:0] m_shift;
	logic m_rot_pass, m_play_q;
	logic m_valid [BLOCK_SLOTS];
	int m_col [BLOCK_SLOTS];
	int m_row [BLOCK_SLOTS];

	tb_clock_gen #(.PERIOD(100)) clock0 (.clock(clock));

	dodge_top #(.STEP_CYCLES(STEP_CYCLES), .SECOND_CYCLES(SECOND_CYCLES)) dut0 (
		.clock(clock), .reset(reset), .go(go), .go2(go2), .buttons(buttons),
		.playing(playing), .game_over(game_over), .direction(direction), .player(player),
		.block_map(block_map), .hex0(hex0), .hex1(hex1)
	);

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			$display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, want);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [6:0] seg_pattern(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0011000;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic logic [MAP_BITS-1:0] model_map();
		logic [MAP_BITS-1:0] map;
		map = '0;
		for (int i = 0; i < BLOCK_SLOTS; i++)
			if (m_valid[i])
				map[m_row[i] * 5 + m_col[i]] = 1'b1;
		return map;
	endfunction

	function automatic row_t make_row(input logic g, input logic g2, input logic [3:0] lrud,
		input int cycles, input int col, input int row, input logic play, input logic over);
		row_t r;
		r.go = g;
		r.go2 = g2;
		r.buttons = '{left: lrud[3], right: lrud[2], up: lrud[1], down: lrud[0]};
		r.cycles = cycles;
		r.col = col;
		r.row = row;
		r.playing = play;
		r.game_over = over;
		return r;
	endfunction

	always @(posedge clock)
	begin : model
		logic play_now, step_due, coll, clear, clear_go, tick, rot;
		int lane, s_col, s_row, d_col, d_row, n_col, n_row;
		buttons_t turned;
		play_now = (m_state == 1);
		step_due = play_now && (m_timer == STEP_CYCLES - 1);
		coll = 1'b0;
		for (int i = 0; i < BLOCK_SLOTS; i++)
			if (m_valid[i] && m_col[i] == p_col && m_row[i] == p_row)
				coll = 1'b1;
		clear = (m_state == 0) && (go || m_rot_pass);
		clear_go = clear && !m_rot_pass; // Only a new game recentres the player
		tick = play_now && (m_tick == SECOND_CYCLES - 1);
		rot = play_now && !coll && go2 && (m_sec > 5); // Seconds as they stand before this edge
		d_col = (m_dir == 2'd3) ? 1 : ((m_dir == 2'd1) ? -1 : 0);
		d_row = (m_dir == 2'd0) ? 1 : ((m_dir == 2'd2) ? -1 : 0);
		lane = m_shift % 5;
		s_col = (d_col < 0) ? 4 : ((d_col > 0) ? 0 : lane); // New blocks enter opposite the travel
		s_row = (d_row < 0) ? 4 : ((d_row > 0) ? 0 : lane);
		case (m_dir)
			2'd1:
				turned = '{left: buttons.down, right: buttons.up,
					up: buttons.left, down: buttons.right};
			2'd2:
				turned = '{left: buttons.right, right: buttons.left,
					up: buttons.down, down: buttons.up};
			2'd3:
				turned = '{left: buttons.up, right: buttons.down,
					up: buttons.right, down: buttons.left};
			default:
				turned = buttons;
		endcase
		model_ready <= 1'b1;
		if (!reset)
		begin
			m_state = 0;
			m_timer = 0;
			m_ptr = 0;
			m_tick = 0;
			m_sec = 0;
			m_ones = 0;
			m_tens = 0;
			p_col = 2;
			p_row = 2;
			m_dir = 2'd0;
			m_shift = 4'b0110;
			m_rot_pass = 0;
			m_play_q = 0;
			foreach (m_valid[i])
				m_valid[i] = 1'b0;
		end
		else
		begin
			if (clear)
			begin
				foreach (m_valid[i])
					m_valid[i] = 1'b0;
				m_ptr = 0;
			end
			else if (step_due)
			begin
				for (int i = 0; i < BLOCK_SLOTS; i++)
				begin
					n_col = m_col[i] + d_col;
					n_row = m_row[i] + d_row;
					if (i == m_ptr)
					begin
						m_valid[i] = 1'b1;
						m_col[i] = s_col;
						m_row[i] = s_row;
					end
					else if (m_valid[i])
					begin
						if (n_col < 0 || n_col > 4 || n_row < 0 || n_row > 4)
							m_valid[i] = 1'b0; // The block has left the grid
						else
						begin
							m_col[i] = n_col;
							m_row[i] = n_row;
						end
					end
				end
				m_ptr = (m_ptr + 1) % BLOCK_SLOTS;
				m_shift = {m_shift[2:0], m_shift[3] ^ m_shift[2]};
			end
			if (clear_go)
			begin
				p_col = 2;
				p_row = 2;
			end
			else if (step_due)
			begin
				if (turned.left && !turned.right && p_col > 0)
					p_col--;
				else if (turned.right && !turned.left && p_col < 4)
					p_col++;
				if (turned.up && !turned.down && p_row > 0)
					p_row--;
				else if (turned.down && !turned.up && p_row < 4)
					p_row++;
			end
			m_timer = (clear || step_due) ? 0 : (play_now ? m_timer + 1 : m_timer);
			m_tick = (!play_now || tick) ? 0 : m_tick + 1;
			if (play_now && !m_play_q)
			begin
				m_sec = 0;
				m_ones = 0;
				m_tens = 0;
			end
			else if (tick)
			begin
				m_sec = (m_sec == 15) ? 15 : m_sec + 1;
				if (m_ones == 9)
					m_tens = (m_tens == 9) ? 0 : m_tens + 1;
				m_ones = (m_ones == 9) ? 0 : m_ones + 1;
			end
			m_play_q = play_now;
			if (rot)
			begin
				m_dir = m_dir + 2'd1;
				m_rot_pass = 1'b1;
			end
			else if (m_state == 0)
				m_rot_pass = 1'b0;
			case (m_state)
				0:
					if (clear)
						m_state = 1;
				1:
					if (coll)
						m_state = 2;
					else if (rot)
						m_state = 0;
				default:
					if (go2)
						m_state = 0;
			endcase
		end
	end

	always @(negedge clock)
	begin
		if (model_ready)
		begin
			check_value("playing", playing, m_state == 1);
			check_value("game_over", game_over, m_state == 2);
			check_value("direction", direction, m_dir);
			check_value("player col", player.col, p_col);
			check_value("player row", player.row, p_row);
			check_value("block_map", block_map, model_map());
			check_value("hex0", hex0, seg_pattern(m_ones));
			check_value("hex1", hex1, seg_pattern(m_tens));
		end
	end

	task automatic check_row(input int r);
		check_value("row player col", player.col, stim_table[r].col);
		check_value("row player row", player.row, stim_table[r].row);
		check_value("row playing", playing, stim_table[r].playing);
		check_value("row game_over", game_over, stim_table[r].game_over);
	endtask

	initial
	begin
		// Buttons are given as left, right, up, down
		stim_table[0] = make_row(0, 0, 4'b0000, 3, 2, 2, 0, 0);
		stim_table[1] = make_row(1, 0, 4'b0000, 1, 2, 2, 1, 0);
		stim_table[2] = make_row(0, 0, 4'b0100, 8, 4, 2, 1, 0);
		stim_table[3] = make_row(0, 0, 4'b0111, 4, 4, 2, 1, 0);
		stim_table[4] = make_row(0, 1, 4'b0001, 4, 4, 3, 1, 0);
		stim_table[5] = make_row(0, 0, 4'b0000, 16, 4, 3, 1, 0);
		stim_table[6] = make_row(0, 0, 4'b0000, 13, 4, 3, 0, 1); // Lane 4 block reaches the player
		stim_table[7] = make_row(0, 0, 4'b0000, 8, 4, 3, 0, 1);
		stim_table[8] = make_row(0, 1, 4'b0000, 1, 4, 3, 0, 0);
		stim_table[9] = make_row(1, 0, 4'b0000, 1, 2, 2, 1, 0);
		stim_table[10] = make_row(0, 0, 4'b0001, 8, 2, 4, 1, 0);
		stim_table[11] = make_row(0, 0, 4'b0000, 8, 2, 4, 1, 0);
		stim_table[12] = make_row(0, 0, 4'b1000, 4, 1, 4, 1, 0);
		stim_table[13] = make_row(0, 0, 4'b0100, 4, 2, 4, 1, 0);
		stim_table[14] = make_row(0, 1, 4'b0000, 20, 2, 4, 1, 0);
		stim_table[15] = make_row(0, 1, 4'b0000, 4, 2, 4, 1, 0);
		stim_table[16] = make_row(0, 1, 4'b0000, 1, 2, 4, 0, 0);
		stim_table[17] = make_row(0, 0, 4'b0000, 1, 2, 4, 1, 0);
		stim_table[18] = make_row(0, 0, 4'b0001, 4, 1, 4, 1, 0); // Down now steps left
		stim_table[19] = make_row(0, 0, 4'b0000, 8, 1, 4, 1, 0);
		reset = 1'b0;
		go = 1'b0;
		go2 = 1'b0;
		buttons = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b1;
		for (int r = 0; r < ROWS; r++)
		begin
			go <= stim_table[r].go;
			go2 <= stim_table[r].go2;
			buttons <= stim_table[r].buttons;
			if (r > 0)
			begin
				@(negedge clock);
				check_row(r - 1);
			end
			repeat (stim_table[r].cycles) @(posedge clock);
		end
		go <= 1'b0;
		go2 <= 1'b0;
		buttons <= '0;
		@(negedge clock);
		check_row(ROWS - 1);
		$display("SIMULATION PASSED");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		#1;
		limit = 10 + 20;
		foreach (stim_table[r]) limit += stim_table[r].cycles;
		#(limit * 100);
		$display("Timeout: the test table did not finish in %0d clock cycles", limit);
		$display("SIMULATION FAILED");
		$fatal(1);
	end

endmodule

//--- flist.f
dodge_pkg.sv
seg_decoder.sv
second_counter.sv
player_mover.sv
block_field.sv
spawn_random.sv
game_control.sv
dodge_top.sv
tb_clock_gen.sv
dodge_tb.sv

//--- Bender.yml
package:
  name: dodge

sources:
  - dodge_pkg.sv
  - seg_decoder.sv
  - second_counter.sv
  - player_mover.sv
  - block_field.sv
  - spawn_random.sv
  - game_control.sv
  - dodge_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - dodge_tb.sv
